// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   // Word address space, byte offset bits dropped
   localparam int addr_w = 30;

   // One instruction
   localparam int insn_w = 32;

   // Fetch packet of two instructions
   localparam int pkt_w = 64;

   // Signed word offset of a relative jump, bits 25 to 0
   localparam int jmp_off_w = 26;

   // Requests the bus fetch unit keeps in flight
   localparam int max_outstanding = 2;

   // Major opcode of a relative jump, bits 31 to 26
   localparam logic [5:0] op_jmprel = 6'h01;

   typedef logic [addr_w-1:0] word_addr_t;

   typedef logic [insn_w-1:0] insn_t;

   // Slot 1 sits in the low half
   typedef struct packed {
      insn_t slot2;
      insn_t slot1;
   } pkt_t;

   // Path tag, bumped on every flush or redirect
   typedef logic [1:0] epoch_t;

endpackage

`default_nettype wire

// File: fetch_pkt_if.sv
`default_nettype none

interface fetch_pkt_if
   import fetch_pkg::*;
   ();

   // Packet handshake
   logic       valid;
   logic       ready;

   // Raw packet from the bus
   pkt_t       data;

   // Fetch PC of the request, low bit set means slot 1 is skipped
   word_addr_t pc;

   // Path the request was issued on
   epoch_t     epoch;

   // Bus fetch unit side
   modport src (output valid, output data, output pc, output epoch, input ready);

   // Issue buffer side
   modport dst (input valid, input data, input pc, input epoch, output ready);

endinterface

`default_nettype wire

// File: fetch_pc_gen.sv
`default_nettype none

module fetch_pc_gen
   import fetch_pkg::*;
   #(
      parameter word_addr_t reset_vector = '0
   )
   (
      input  logic       clk,
      input  logic       reset,
      // External flush
      input  logic       flush,
      input  word_addr_t flush_tgt,
      // Taken relative jump from the issue buffer
      input  logic       redirect,
      input  word_addr_t redirect_tgt,
      // Request accepted by the bus
      input  logic       req_take,
      // Current fetch point
      output word_addr_t fetch_pc,
      output epoch_t     fetch_epoch,
      output epoch_t     cur_epoch
   );

   word_addr_t pc_q;
   word_addr_t pc_d;
   word_addr_t seq_pc;
   epoch_t     epoch_q;
   epoch_t     epoch_d;

   // Next packet boundary, an odd PC still moves to the following packet
   assign seq_pc = {pc_q[addr_w-1:1] + 1'b1, 1'b0};

   // Flush first, then redirect, then sequential flow
   always_comb
   begin
      pc_d    = pc_q;
      epoch_d = epoch_q;
      if (flush)
      begin
         pc_d    = flush_tgt;
         epoch_d = epoch_q + 1'b1;
      end
      else if (redirect)
      begin
         pc_d    = redirect_tgt;
         epoch_d = epoch_q + 1'b1;
      end
      else if (req_take)
      begin
         pc_d = seq_pc;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc_q    <= reset_vector;
         epoch_q <= '0;
      end
      else
      begin
         pc_q    <= pc_d;
         epoch_q <= epoch_d;
      end
   end

   assign fetch_pc = pc_q;

   // Requests are tagged with the path they belong to
   assign fetch_epoch = epoch_q;

   // Live path, anything tagged otherwise is stale
   assign cur_epoch = epoch_q;

endmodule

`default_nettype wire

// File: ibus_fetch.sv
`default_nettype none

module ibus_fetch
   import fetch_pkg::*;
   (
      input  logic             clk,
      input  logic             reset,
      // Fetch point from the PC generator
      input  word_addr_t       fetch_pc,
      input  epoch_t           fetch_epoch,
      input  logic             flush,
      input  logic             redirect,
      output logic             req_take,
      // Bus request channel
      output logic             ibus_ar_valid,
      output word_addr_t       ibus_ar_addr,
      input  logic             ibus_ar_ready,
      // Bus response channel
      input  logic             ibus_r_valid,
      input  logic [pkt_w-1:0] ibus_r_data,
      output logic             ibus_r_ready,
      // Packet towards the issue buffer
      fetch_pkt_if.src         pkt
   );

   localparam int ptr_w = $clog2(max_outstanding);
   localparam int cnt_w = $clog2(max_outstanding + 1);

   logic [cnt_w-1:0] cnt_q;
   logic [ptr_w-1:0] wr_ptr_q;
   logic [ptr_w-1:0] rd_ptr_q;
   word_addr_t       q_pc [max_outstanding];
   epoch_t           q_epoch [max_outstanding];
   logic             hold_q;
   logic             hold_stale_q;
   word_addr_t       hold_pc_q;
   epoch_t           hold_epoch_q;
   word_addr_t       req_pc;
   epoch_t           req_epoch;
   logic             ar_fire;
   logic             r_fire;

   // A request left waiting keeps its address until the bus takes it
   assign req_pc    = hold_q ? hold_pc_q : fetch_pc;
   assign req_epoch = hold_q ? hold_epoch_q : fetch_epoch;

   // New request only out of reset, with room in flight and no path change this cycle
   assign ibus_ar_valid = ~reset &
                          (hold_q | ((cnt_q < max_outstanding) & ~flush & ~redirect));
   assign ibus_ar_addr  = {req_pc[addr_w-1:1], 1'b0};
   assign ar_fire       = ibus_ar_valid & ibus_ar_ready;

   // PC generator moved on already if the held request went stale
   assign req_take = ar_fire & ~(hold_q & hold_stale_q);

   // Responses come back in order and pair with the queue head
   assign pkt.valid    = ibus_r_valid;
   assign pkt.data     = ibus_r_data;
   assign pkt.pc       = q_pc[rd_ptr_q];
   assign pkt.epoch    = q_epoch[rd_ptr_q];
   assign ibus_r_ready = pkt.ready;
   assign r_fire       = ibus_r_valid & pkt.ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cnt_q        <= '0;
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         hold_q       <= 1'b0;
         hold_stale_q <= 1'b0;
      end
      else
      begin
         cnt_q <= cnt_q + cnt_w'(ar_fire) - cnt_w'(r_fire);
         if (ar_fire)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (r_fire)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         hold_q <= ibus_ar_valid & ~ibus_ar_ready;
         // Remember a flush or redirect seen while waiting on the bus
         if (ibus_ar_valid & ~ibus_ar_ready)
            hold_stale_q <= (hold_q & hold_stale_q) | flush | redirect;
         else
            hold_stale_q <= 1'b0;
      end
   end

   // Request PC and tag for each request in flight
   always_ff @(posedge clk)
   begin
      if (ar_fire)
      begin
         q_pc[wr_ptr_q]    <= req_pc;
         q_epoch[wr_ptr_q] <= req_epoch;
      end
      if (ibus_ar_valid & ~ibus_ar_ready)
      begin
         hold_pc_q    <= req_pc;
         hold_epoch_q <= req_epoch;
      end
   end

endmodule

`default_nettype wire

// File: jump_predecode.sv
`default_nettype none

module jump_predecode
   import fetch_pkg::*;
   (
      input  insn_t      insn,
      input  word_addr_t pc,
      output logic       is_jmprel,
      output word_addr_t jmp_tgt
   );

   word_addr_t off_ext;

   // Major opcode only, no further fields matter here
   assign is_jmprel = (insn[insn_w-1:jmp_off_w] == op_jmprel);

   // Word offset, sign extended to the address width
   assign off_ext = {{(addr_w - jmp_off_w){insn[jmp_off_w-1]}}, insn[jmp_off_w-1:0]};

   // Relative to the jump itself
   assign jmp_tgt = pc + off_ext;

endmodule

`default_nettype wire

// File: issue_buffer.sv
`default_nettype none

module issue_buffer
   import fetch_pkg::*;
   (
      input  logic       clk,
      input  logic       reset,
      input  epoch_t     cur_epoch,
      // Packet from the bus fetch unit
      fetch_pkt_if.dst   pkt,
      // Decoder handshake
      output logic       out_valid,
      input  logic       out_ready,
      output logic       slot1_valid,
      output insn_t      slot1_insn,
      output word_addr_t slot1_pc,
      output logic       slot2_valid,
      output insn_t      slot2_insn,
      output word_addr_t slot2_pc,
      // Taken relative jump back to the PC generator
      output logic       redirect,
      output word_addr_t redirect_tgt
   );

   logic       valid_q;
   pkt_t       data_q;
   word_addr_t pc_q;
   epoch_t     epoch_q;
   logic       live;
   logic       jmp1;
   logic       jmp2;
   word_addr_t tgt1;
   word_addr_t tgt2;
   logic       take1;
   logic       take2;

   // Stored packet dies as soon as the path moves on
   assign live      = valid_q & (epoch_q == cur_epoch);
   assign out_valid = live;

   // Room when empty, stale or being drained this cycle
   assign pkt.ready = ~live | out_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
         valid_q <= 1'b0;
      else if (pkt.ready)
         valid_q <= pkt.valid & (pkt.epoch == cur_epoch);
   end

   always_ff @(posedge clk)
   begin
      if (pkt.valid & pkt.ready)
      begin
         data_q  <= pkt.data;
         pc_q    <= pkt.pc;
         epoch_q <= pkt.epoch;
      end
   end

   // Both slots share the packet base
   assign slot1_pc   = {pc_q[addr_w-1:1], 1'b0};
   assign slot2_pc   = {pc_q[addr_w-1:1], 1'b1};
   assign slot1_insn = data_q.slot1;
   assign slot2_insn = data_q.slot2;

   jump_predecode u_predecode1
      (
         .insn      (slot1_insn),
         .pc        (slot1_pc),
         .is_jmprel (jmp1),
         .jmp_tgt   (tgt1)
      );

   jump_predecode u_predecode2
      (
         .insn      (slot2_insn),
         .pc        (slot2_pc),
         .is_jmprel (jmp2),
         .jmp_tgt   (tgt2)
      );

   // Slot 1 only from an aligned fetch PC
   assign slot1_valid = live & ~pc_q[0];
   assign take1       = slot1_valid & jmp1;

   // Younger slot is dropped behind a jump in slot 1
   assign slot2_valid = live & ~take1;
   assign take2       = slot2_valid & jmp2;

   // Oldest jumping slot wins, raised only on acceptance
   assign redirect     = live & out_ready & (take1 | take2);
   assign redirect_tgt = take1 ? tgt1 : tgt2;

endmodule

`default_nettype wire

// File: ifu_frontend.sv
`default_nettype none

module ifu_frontend
   import fetch_pkg::*;
   #(
      parameter word_addr_t reset_vector = '0
   )
   (
      input  logic             clk,
      input  logic             reset,
      // Bus request channel
      output logic             ibus_ar_valid,
      output word_addr_t       ibus_ar_addr,
      input  logic             ibus_ar_ready,
      // Bus response channel
      input  logic             ibus_r_valid,
      input  logic [pkt_w-1:0] ibus_r_data,
      output logic             ibus_r_ready,
      // Flush from the back end
      input  logic             flush,
      input  word_addr_t       flush_tgt,
      // Decoder side
      output logic             out_valid,
      input  logic             out_ready,
      output logic             slot1_valid,
      output insn_t            slot1_insn,
      output word_addr_t       slot1_pc,
      output logic             slot2_valid,
      output insn_t            slot2_insn,
      output word_addr_t       slot2_pc
   );

   word_addr_t fetch_pc;
   epoch_t     fetch_epoch;
   epoch_t     cur_epoch;
   logic       req_take;
   logic       redirect;
   word_addr_t redirect_tgt;

   // Bus response to issue buffer
   fetch_pkt_if pkt_if ();

   fetch_pc_gen #(.reset_vector (reset_vector)) u_pc_gen
      (
         .clk          (clk),
         .reset        (reset),
         .flush        (flush),
         .flush_tgt    (flush_tgt),
         .redirect     (redirect),
         .redirect_tgt (redirect_tgt),
         .req_take     (req_take),
         .fetch_pc     (fetch_pc),
         .fetch_epoch  (fetch_epoch),
         .cur_epoch    (cur_epoch)
      );

   ibus_fetch u_ibus_fetch
      (
         .clk           (clk),
         .reset         (reset),
         .fetch_pc      (fetch_pc),
         .fetch_epoch   (fetch_epoch),
         .flush         (flush),
         .redirect      (redirect),
         .req_take      (req_take),
         .ibus_ar_valid (ibus_ar_valid),
         .ibus_ar_addr  (ibus_ar_addr),
         .ibus_ar_ready (ibus_ar_ready),
         .ibus_r_valid  (ibus_r_valid),
         .ibus_r_data   (ibus_r_data),
         .ibus_r_ready  (ibus_r_ready),
         .pkt           (pkt_if.src)
      );

   issue_buffer u_issue_buffer
      (
         .clk          (clk),
         .reset        (reset),
         .cur_epoch    (cur_epoch),
         .pkt          (pkt_if.dst),
         .out_valid    (out_valid),
         .out_ready    (out_ready),
         .slot1_valid  (slot1_valid),
         .slot1_insn   (slot1_insn),
         .slot1_pc     (slot1_pc),
         .slot2_valid  (slot2_valid),
         .slot2_insn   (slot2_insn),
         .slot2_pc     (slot2_pc),
         .redirect     (redirect),
         .redirect_tgt (redirect_tgt)
      );

endmodule

`default_nettype wire

// File: tb_frontend_asserts.sv
`default_nettype none

module tb_frontend_asserts
   import fetch_pkg::*;
   (
      input logic       clk,
      input logic       reset,
      input logic       ibus_ar_valid,
      input word_addr_t ibus_ar_addr,
      input logic       ibus_ar_ready,
      input logic       flush,
      input logic       out_valid,
      input logic       out_ready,
      input logic       slot1_valid,
      input insn_t      slot1_insn,
      input word_addr_t slot1_pc,
      input logic       slot2_valid,
      input insn_t      slot2_insn,
      input word_addr_t slot2_pc
   );

   int fail_count = 0;

   // Request held with its address until the bus takes it
   ar_stable : assert property (@(posedge clk) disable iff (reset)
      ibus_ar_valid && !ibus_ar_ready |=> ibus_ar_valid && $stable(ibus_ar_addr))
   else
   begin
      fail_count++;
      $error("bus request dropped or changed before acceptance");
   end

   // A flush may kill the held packet, otherwise it stays put
   out_stable : assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready && !flush |=> out_valid &&
      $stable({slot1_valid, slot1_insn, slot1_pc, slot2_valid, slot2_insn, slot2_pc}))
   else
   begin
      fail_count++;
      $error("output changed while held by the decoder");
   end

   // Younger slot behind a slot 1 jump
   no_slot2_after_jump : assert property (@(posedge clk) disable iff (reset)
      slot1_valid && (slot1_insn[31:26] == op_jmprel) |-> !slot2_valid)
   else
   begin
      fail_count++;
      $error("slot 2 valid behind a jump in slot 1");
   end

   out_idle_after_reset : assert property (@(posedge clk) reset |=> !out_valid)
   else
   begin
      fail_count++;
      $error("output valid right after reset");
   end

endmodule

bind ifu_frontend tb_frontend_asserts u_asserts
   (
      .clk           (clk),
      .reset         (reset),
      .ibus_ar_valid (ibus_ar_valid),
      .ibus_ar_addr  (ibus_ar_addr),
      .ibus_ar_ready (ibus_ar_ready),
      .flush         (flush),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .slot1_valid   (slot1_valid),
      .slot1_insn    (slot1_insn),
      .slot1_pc      (slot1_pc),
      .slot2_valid   (slot2_valid),
      .slot2_insn    (slot2_insn),
      .slot2_pc      (slot2_pc)
   );

`default_nettype wire

// File: tb_frontend.sv
`default_nettype none

module tb_frontend
   import fetch_pkg::*;
   ();

   logic             clk;
   logic             reset;
   logic             ibus_ar_valid;
   word_addr_t       ibus_ar_addr;
   logic             ibus_ar_ready;
   logic             ibus_r_valid;
   logic [pkt_w-1:0] ibus_r_data;
   logic             ibus_r_ready;
   logic             flush;
   word_addr_t       flush_tgt;
   logic             out_valid;
   logic             out_ready;
   logic             slot1_valid;
   insn_t            slot1_insn;
   word_addr_t       slot1_pc;
   logic             slot2_valid;
   insn_t            slot2_insn;
   word_addr_t       slot2_pc;

   integer           seed = 33;
   logic             random_mode;
   string            test_name;
   word_addr_t       exp_pc;
   int               insn_count;
   // Packet addresses accepted by the bus with the oldest first
   word_addr_t       req_q [$];

   ifu_frontend #(.reset_vector ('h100)) uut
      (
         .clk           (clk),
         .reset         (reset),
         .ibus_ar_valid (ibus_ar_valid),
         .ibus_ar_addr  (ibus_ar_addr),
         .ibus_ar_ready (ibus_ar_ready),
         .ibus_r_valid  (ibus_r_valid),
         .ibus_r_data   (ibus_r_data),
         .ibus_r_ready  (ibus_r_ready),
         .flush         (flush),
         .flush_tgt     (flush_tgt),
         .out_valid     (out_valid),
         .out_ready     (out_ready),
         .slot1_valid   (slot1_valid),
         .slot1_insn    (slot1_insn),
         .slot1_pc      (slot1_pc),
         .slot2_valid   (slot2_valid),
         .slot2_insn    (slot2_insn),
         .slot2_pc      (slot2_pc)
      );

   // Relative jump with a signed word offset
   function automatic insn_t jump_word(input int off);
      jump_word = {op_jmprel, off[jmp_off_w-1:0]};
   endfunction

   // Jump offsets of the program, zero where a filler word sits
   function automatic int jump_offset(input word_addr_t addr);
      case (addr)
         30'h103: jump_offset = 6;
         30'h10C: jump_offset = 5;
         30'h114: jump_offset = -20;
         30'h207: jump_offset = -7;
         default: jump_offset = 0;
      endcase
   endfunction

   // Program image looping through 100..103 then 109..10C then 111..114
   // Flush target 203 runs 203..207 and then loops 200..207
   function automatic insn_t mem_word(input word_addr_t addr);
      int off;
      off = jump_offset(addr);
      // Top bits 11 keep filler words off the jump opcode
      if (off != 0)
         mem_word = jump_word(off);
      else
         mem_word = {2'b11, addr ^ 30'h2A5A5A5};
   endfunction

   // Next executed word address
   function automatic word_addr_t ref_next(input word_addr_t addr);
      int off;
      off = jump_offset(addr);
      if (off != 0)
         ref_next = addr + word_addr_t'(off);
      else
         ref_next = addr + 1'b1;
   endfunction

   task automatic report_error(input string what);
      $display("Error in test %s: %s", test_name, what);
      $display("Test failures found");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      $display("Test failures found");
      $fatal(1, "Simulation stopped at first error");
   endtask

   // Checks one output transfer with the oldest slot first
   task automatic check_packet();
      word_addr_t base;
      logic       exp_s1;
      logic       exp_s2;
      base   = {exp_pc[addr_w-1:1], 1'b0};
      exp_s1 = ~exp_pc[0];
      assert (slot1_valid == exp_s1)
      else report_mismatch("slot1_valid", exp_s1, slot1_valid);
      if (slot1_valid)
      begin
         assert (slot1_pc == exp_pc) else report_mismatch("slot1_pc", exp_pc, slot1_pc);
         assert (slot1_insn == mem_word(exp_pc))
         else report_mismatch("slot1_insn", mem_word(exp_pc), slot1_insn);
         exp_pc = ref_next(exp_pc);
         insn_count++;
      end
      // Slot 2 only if the stream simply falls through to it
      exp_s2 = (exp_pc == {base[addr_w-1:1], 1'b1});
      assert (slot2_valid == exp_s2) else report_mismatch("slot2_valid", exp_s2, slot2_valid);
      if (slot2_valid)
      begin
         assert (slot2_pc == exp_pc) else report_mismatch("slot2_pc", exp_pc, slot2_pc);
         assert (slot2_insn == mem_word(exp_pc))
         else report_mismatch("slot2_insn", mem_word(exp_pc), slot2_insn);
         exp_pc = ref_next(exp_pc);
         insn_count++;
      end
   endtask

   task automatic wait_for_insns(input int target, input int limit);
      int cycles;
      cycles = 0;
      while (insn_count < target && cycles < limit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (insn_count < target)
         report_error($sformatf("timed out waiting for %0d instructions", target));
   endtask

   task automatic apply_flush(input word_addr_t tgt);
      @(negedge clk);
      flush     = 1'b1;
      flush_tgt = tgt;
      @(negedge clk);
      flush = 1'b0;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Bus slave and decoder ready
   initial
   begin : drive_inputs
      word_addr_t base;
      logic       r_done;
      forever
      begin
         @(posedge clk);
         r_done = 1'b0;
         if (!reset && ibus_ar_valid && ibus_ar_ready)
            req_q.push_back(ibus_ar_addr);
         if (!reset && ibus_r_valid && ibus_r_ready)
         begin
            void'(req_q.pop_front());
            r_done = 1'b1;
         end
         @(negedge clk);
         ibus_ar_ready = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
         out_ready     = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
         // Response held stable until taken and returned in request order
         if (!ibus_r_valid || r_done)
         begin
            if (req_q.size() > 0 && (!random_mode || ($random(seed) & 1)))
            begin
               base         = req_q[0];
               ibus_r_valid = 1'b1;
               ibus_r_data  = {mem_word(base + 1'b1), mem_word(base)};
            end
            else
               ibus_r_valid = 1'b0;
         end
      end
   end

   // Compare every transfer with the expected stream
   initial
   begin : compare_stream
      int idle;
      idle = 0;
      forever
      begin
         @(posedge clk);
         if (!reset)
         begin
            assert (uut.u_asserts.fail_count == 0)
            else report_error("a bus or output handshake property failed");
            if (out_valid && out_ready)
            begin
               idle = 0;
               check_packet();
            end
            else
            begin
               idle++;
               if (idle > 200)
                  report_error("no output transfer for 200 cycles");
            end
            // Transfer in the flush cycle still belongs to the old path
            if (flush)
               exp_pc = flush_tgt;
         end
      end
   end

   initial
   begin
      reset         = 1'b1;
      flush         = 1'b0;
      flush_tgt     = '0;
      out_ready     = 1'b0;
      ibus_ar_ready = 1'b0;
      ibus_r_valid  = 1'b0;
      ibus_r_data   = '0;
      random_mode   = 1'b0;
      exp_pc        = 'h100;
      insn_count    = 0;
      test_name     = "sequential";
      repeat (4) @(negedge clk);
      reset = 1'b0;

      // Reset vector then jumps in both slots and odd targets
      wait_for_insns(40, 2000);

      test_name = "flush";
      apply_flush('h203);
      wait_for_insns(insn_count + 30, 2000);

      // Random stalls on the bus and the decoder
      test_name   = "random";
      random_mode = 1'b1;
      wait_for_insns(insn_count + 100, 10000);
      apply_flush('h10C);
      wait_for_insns(insn_count + 500, 40000);

      @(negedge clk);
      if (uut.u_asserts.fail_count == 0)
      begin
         $display("All tests passed!");
         $finish;
      end
      else
      begin
         $display("Test failures found");
         $fatal(1, "Handshake property failures at end of run");
      end
   end

endmodule

`default_nettype wire

// File: tb.f
fetch_pkg.sv
fetch_pkt_if.sv
fetch_pc_gen.sv
ibus_fetch.sv
jump_predecode.sv
issue_buffer.sv
ifu_frontend.sv
tb_frontend_asserts.sv
tb_frontend.sv

// File: Bender.yml
package:
  name: ifu_frontend

sources:
  - fetch_pkg.sv
  - fetch_pkt_if.sv
  - fetch_pc_gen.sv
  - ibus_fetch.sv
  - jump_predecode.sv
  - issue_buffer.sv
  - ifu_frontend.sv
  - target: simulation
    files:
      - tb_frontend_asserts.sv
      - tb_frontend.sv
